/* source/mips_ex_pkg.sv */
// ==================================================
// Execute stage shared types
// ==================================================

package mips_ex_pkg;

	// ==================================================
	// word and field types
	// ==================================================
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [5:0]  funct_t;

	// shamt field position inside the sign-extended immediate
	localparam int SHAMT_LSB = 6;

	// ==================================================
	// op codes
	// ==================================================
	// alu op code from the main decoder
	typedef enum logic [1:0]
	{
		ALUOP_ADD   = 2'b00,
		ALUOP_SUB   = 2'b01,
		ALUOP_FUNCT = 2'b10,
		ALUOP_OTHER = 2'b11
	} alu_op_t;

	// extra code for immediate instructions
	typedef enum logic [3:0]
	{
		IMM_ADDI  = 4'd0,
		IMM_ANDI  = 4'd1,
		IMM_ORI   = 4'd2,
		IMM_XORI  = 4'd3,
		IMM_SLTI  = 4'd4,
		IMM_SLTIU = 4'd5,
		IMM_LUI   = 4'd6
	} imm_op_t;

	// operation seen by the ALU
	typedef enum logic [3:0]
	{
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		NOR  = 4'd5,
		SLT  = 4'd6,
		SLTU = 4'd7,
		SLL  = 4'd8,
		SRL  = 4'd9,
		SRA  = 4'd10,
		SLLV = 4'd11,
		SRLV = 4'd12,
		SRAV = 4'd13,
		LUI  = 4'd14
	} alu_ctrl_t;

	// R-type function codes
	localparam funct_t FUNCT_SLL  = 6'h00;
	localparam funct_t FUNCT_SRL  = 6'h02;
	localparam funct_t FUNCT_SRA  = 6'h03;
	localparam funct_t FUNCT_SLLV = 6'h04;
	localparam funct_t FUNCT_SRLV = 6'h06;
	localparam funct_t FUNCT_SRAV = 6'h07;
	localparam funct_t FUNCT_ADD  = 6'h20;
	localparam funct_t FUNCT_ADDU = 6'h21;
	localparam funct_t FUNCT_SUB  = 6'h22;
	localparam funct_t FUNCT_SUBU = 6'h23;
	localparam funct_t FUNCT_AND  = 6'h24;
	localparam funct_t FUNCT_OR   = 6'h25;
	localparam funct_t FUNCT_XOR  = 6'h26;
	localparam funct_t FUNCT_NOR  = 6'h27;
	localparam funct_t FUNCT_SLT  = 6'h2a;
	localparam funct_t FUNCT_SLTU = 6'h2b;

endpackage

/* source/alu_if.sv */
// ==================================================
// ALU operand and result bundle
// ==================================================

interface alu_if;

	// operands from the stage
	mips_ex_pkg::word_t     a;
	mips_ex_pkg::word_t     b;
	mips_ex_pkg::shamt_t    shamt;
	mips_ex_pkg::funct_t    funct;
	// operation from the decoder
	mips_ex_pkg::alu_ctrl_t op;
	// ALU outputs
	mips_ex_pkg::word_t     result;
	logic                   zero;

	modport stage
	(
		output a, b, shamt, funct,
		input  result, zero
	);

	modport decode
	(
		input  funct,
		output op
	);

	modport alu
	(
		input  a, b, shamt, op,
		output result, zero
	);

endinterface

/* source/alu_decode.sv */
// ==================================================
// ALU control decoder
// ==================================================

module alu_decode
(
	input  mips_ex_pkg::alu_op_t i_aluop,
	input  mips_ex_pkg::imm_op_t i_other,
	alu_if.decode                o_alu
);

	// ==================================================
	// R-type function mapping
	// ==================================================
	mips_ex_pkg::alu_ctrl_t funct_op;

	always_comb
	begin
		case (o_alu.funct)
			mips_ex_pkg::FUNCT_ADD,
			mips_ex_pkg::FUNCT_ADDU: funct_op = mips_ex_pkg::ADD;
			mips_ex_pkg::FUNCT_SUB,
			mips_ex_pkg::FUNCT_SUBU: funct_op = mips_ex_pkg::SUB;
			mips_ex_pkg::FUNCT_AND:  funct_op = mips_ex_pkg::AND;
			mips_ex_pkg::FUNCT_OR:   funct_op = mips_ex_pkg::OR;
			mips_ex_pkg::FUNCT_XOR:  funct_op = mips_ex_pkg::XOR;
			mips_ex_pkg::FUNCT_NOR:  funct_op = mips_ex_pkg::NOR;
			mips_ex_pkg::FUNCT_SLT:  funct_op = mips_ex_pkg::SLT;
			mips_ex_pkg::FUNCT_SLTU: funct_op = mips_ex_pkg::SLTU;
			mips_ex_pkg::FUNCT_SLL:  funct_op = mips_ex_pkg::SLL;
			mips_ex_pkg::FUNCT_SRL:  funct_op = mips_ex_pkg::SRL;
			mips_ex_pkg::FUNCT_SRA:  funct_op = mips_ex_pkg::SRA;
			mips_ex_pkg::FUNCT_SLLV: funct_op = mips_ex_pkg::SLLV;
			mips_ex_pkg::FUNCT_SRLV: funct_op = mips_ex_pkg::SRLV;
			mips_ex_pkg::FUNCT_SRAV: funct_op = mips_ex_pkg::SRAV;
			// unknown function codes fall back to add
			default:                 funct_op = mips_ex_pkg::ADD;
		endcase
	end

	// ==================================================
	// top level selection
	// ==================================================
	always_comb
	begin
		case (i_aluop)
			mips_ex_pkg::ALUOP_ADD:   o_alu.op = mips_ex_pkg::ADD;
			mips_ex_pkg::ALUOP_SUB:   o_alu.op = mips_ex_pkg::SUB;
			mips_ex_pkg::ALUOP_FUNCT: o_alu.op = funct_op;
			mips_ex_pkg::ALUOP_OTHER:
			begin
				// immediate ops, logical ones use the sign-extended value
				case (i_other)
					mips_ex_pkg::IMM_ANDI:  o_alu.op = mips_ex_pkg::AND;
					mips_ex_pkg::IMM_ORI:   o_alu.op = mips_ex_pkg::OR;
					mips_ex_pkg::IMM_XORI:  o_alu.op = mips_ex_pkg::XOR;
					mips_ex_pkg::IMM_SLTI:  o_alu.op = mips_ex_pkg::SLT;
					mips_ex_pkg::IMM_SLTIU: o_alu.op = mips_ex_pkg::SLTU;
					mips_ex_pkg::IMM_LUI:   o_alu.op = mips_ex_pkg::LUI;
					default:                o_alu.op = mips_ex_pkg::ADD;
				endcase
			end
			default:                  o_alu.op = mips_ex_pkg::ADD;
		endcase
	end

	// known inputs always give a known operation
	always_comb
	begin
		if (!$isunknown({i_aluop, i_other, o_alu.funct}))
			assert (!$isunknown(o_alu.op))
			else $error("alu_decode: unknown operation from known inputs");
	end

endmodule

/* source/alu.sv */
// ==================================================
// 32-bit integer ALU
// ==================================================

module alu
(
	alu_if.alu i_alu
);

	// variable shift amount from rs
	mips_ex_pkg::shamt_t var_shamt;
	mips_ex_pkg::word_t  result;

	assign var_shamt = i_alu.a[4:0];

	// ==================================================
	// operation select
	// ==================================================
	always_comb
	begin
		case (i_alu.op)
			mips_ex_pkg::ADD:  result = i_alu.a + i_alu.b;
			mips_ex_pkg::SUB:  result = i_alu.a - i_alu.b;
			mips_ex_pkg::AND:  result = i_alu.a & i_alu.b;
			mips_ex_pkg::OR:   result = i_alu.a | i_alu.b;
			mips_ex_pkg::XOR:  result = i_alu.a ^ i_alu.b;
			mips_ex_pkg::NOR:  result = ~(i_alu.a | i_alu.b);
			// compares give 1 or 0
			mips_ex_pkg::SLT:
			begin
				result = {31'b0, $signed(i_alu.a) < $signed(i_alu.b)};
			end
			mips_ex_pkg::SLTU:
			begin
				result = {31'b0, i_alu.a < i_alu.b};
			end
			// fixed shifts by the shamt field
			mips_ex_pkg::SLL:  result = i_alu.b << i_alu.shamt;
			mips_ex_pkg::SRL:  result = i_alu.b >> i_alu.shamt;
			mips_ex_pkg::SRA:
			begin
				result = mips_ex_pkg::word_t'($signed(i_alu.b) >>> i_alu.shamt);
			end
			// variable shifts by rs
			mips_ex_pkg::SLLV: result = i_alu.b << var_shamt;
			mips_ex_pkg::SRLV: result = i_alu.b >> var_shamt;
			mips_ex_pkg::SRAV:
			begin
				result = mips_ex_pkg::word_t'($signed(i_alu.b) >>> var_shamt);
			end
			// low half of b moves to the top
			mips_ex_pkg::LUI:  result = {i_alu.b[15:0], 16'b0};
			default:           result = '0;
		endcase
	end

	assign i_alu.result = result;
	assign i_alu.zero   = (result == '0);

	// branch compare sees zero exactly for equal operands
	always_comb
	begin
		if (i_alu.op == mips_ex_pkg::SUB && !$isunknown({i_alu.a, i_alu.b}))
			assert (i_alu.zero == (i_alu.a == i_alu.b))
			else $error("alu: zero flag disagrees with operand compare");
	end

endmodule

/* source/execute.sv */
// ==================================================
// Execute stage and EX/MEM register
// ==================================================

module execute
(
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// control from decode
	input  logic                   i_regdst,
	input  logic                   i_alusrc,
	input  logic                   i_branch,
	input  logic                   i_memread,
	input  logic                   i_memwrite,
	input  logic                   i_memtoreg,
	input  logic                   i_regwrite,
	// data from decode
	input  mips_ex_pkg::word_t     i_next_pc,
	input  mips_ex_pkg::word_t     i_rs,
	input  mips_ex_pkg::word_t     i_rt,
	input  mips_ex_pkg::word_t     i_imm,
	input  mips_ex_pkg::reg_addr_t i_rt_addr,
	input  mips_ex_pkg::reg_addr_t i_rd_addr,
	// ALU connection
	alu_if.stage                   o_alu,
	// EX/MEM outputs
	output logic                   o_branch,
	output logic                   o_memread,
	output logic                   o_memwrite,
	output logic                   o_memtoreg,
	output logic                   o_regwrite,
	output logic                   o_zero,
	output mips_ex_pkg::word_t     o_branch_target,
	output mips_ex_pkg::word_t     o_alu_result,
	output mips_ex_pkg::word_t     o_rt,
	output mips_ex_pkg::reg_addr_t o_dest_addr
);

	mips_ex_pkg::word_t     branch_target;
	mips_ex_pkg::reg_addr_t dest_addr;

	// ==================================================
	// operand and field selection
	// ==================================================
	assign o_alu.a     = i_rs;
	assign o_alu.b     = i_alusrc ? i_imm : i_rt;
	assign o_alu.shamt = i_imm[mips_ex_pkg::SHAMT_LSB +: $bits(mips_ex_pkg::shamt_t)];
	assign o_alu.funct = i_imm[$bits(mips_ex_pkg::funct_t)-1:0];

	// rd for R-type, rt otherwise
	assign dest_addr = i_regdst ? i_rd_addr : i_rt_addr;

	// word offset turned into a byte offset
	assign branch_target = i_next_pc + {i_imm[29:0], 2'b00};

	// ==================================================
	// EX/MEM pipeline register
	// ==================================================
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_branch        <= 1'b0;
			o_memread       <= 1'b0;
			o_memwrite      <= 1'b0;
			o_memtoreg      <= 1'b0;
			o_regwrite      <= 1'b0;
			o_zero          <= 1'b0;
			o_branch_target <= '0;
			o_alu_result    <= '0;
			o_rt            <= '0;
			o_dest_addr     <= '0;
		end
		else
		begin
			o_branch        <= i_branch;
			o_memread       <= i_memread;
			o_memwrite      <= i_memwrite;
			o_memtoreg      <= i_memtoreg;
			o_regwrite      <= i_regwrite;
			o_zero          <= o_alu.zero;
			o_branch_target <= branch_target;
			o_alu_result    <= o_alu.result;
			o_rt            <= i_rt;
			o_dest_addr     <= dest_addr;
		end
	end

	// a memory access is either a load or a store
	a_mem_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_memread && o_memwrite))
		else $error("execute: memread and memwrite both set");

endmodule

/* source/exec_top.sv */
// ==================================================
// Execute stage top level
// ==================================================

module exec_top
(
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// control
	input  logic                   i_regdst,
	input  logic                   i_alusrc,
	input  mips_ex_pkg::alu_op_t   i_aluop,
	input  mips_ex_pkg::imm_op_t   i_other,
	input  logic                   i_branch,
	input  logic                   i_memread,
	input  logic                   i_memwrite,
	input  logic                   i_memtoreg,
	input  logic                   i_regwrite,
	// data
	input  mips_ex_pkg::word_t     i_next_pc,
	input  mips_ex_pkg::word_t     i_rs,
	input  mips_ex_pkg::word_t     i_rt,
	input  mips_ex_pkg::word_t     i_imm,
	input  mips_ex_pkg::reg_addr_t i_rt_addr,
	input  mips_ex_pkg::reg_addr_t i_rd_addr,
	// EX/MEM outputs
	output logic                   o_branch,
	output logic                   o_memread,
	output logic                   o_memwrite,
	output logic                   o_memtoreg,
	output logic                   o_regwrite,
	output logic                   o_zero,
	output mips_ex_pkg::word_t     o_branch_target,
	output mips_ex_pkg::word_t     o_alu_result,
	output mips_ex_pkg::word_t     o_rt,
	output mips_ex_pkg::reg_addr_t o_dest_addr
);

	alu_if u_alu_if();

	execute u_execute
	(
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_regdst        (i_regdst),
		.i_alusrc        (i_alusrc),
		.i_branch        (i_branch),
		.i_memread       (i_memread),
		.i_memwrite      (i_memwrite),
		.i_memtoreg      (i_memtoreg),
		.i_regwrite      (i_regwrite),
		.i_next_pc       (i_next_pc),
		.i_rs            (i_rs),
		.i_rt            (i_rt),
		.i_imm           (i_imm),
		.i_rt_addr       (i_rt_addr),
		.i_rd_addr       (i_rd_addr),
		.o_alu           (u_alu_if.stage),
		.o_branch        (o_branch),
		.o_memread       (o_memread),
		.o_memwrite      (o_memwrite),
		.o_memtoreg      (o_memtoreg),
		.o_regwrite      (o_regwrite),
		.o_zero          (o_zero),
		.o_branch_target (o_branch_target),
		.o_alu_result    (o_alu_result),
		.o_rt            (o_rt),
		.o_dest_addr     (o_dest_addr)
	);

	alu_decode u_alu_decode
	(
		.i_aluop (i_aluop),
		.i_other (i_other),
		.o_alu   (u_alu_if.decode)
	);

	alu u_alu
	(
		.i_alu (u_alu_if.alu)
	);

endmodule

/* verif/ex_checker.sv */
// ==================================================
// Execute stage output checker
// ==================================================

module ex_checker
(
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// DUT inputs
	input  logic                   i_regdst,
	input  logic                   i_alusrc,
	input  logic [1:0]             i_aluop,
	input  logic [3:0]             i_other,
	input  logic                   i_branch,
	input  logic                   i_memread,
	input  logic                   i_memwrite,
	input  logic                   i_memtoreg,
	input  logic                   i_regwrite,
	input  mips_ex_pkg::word_t     i_next_pc,
	input  mips_ex_pkg::word_t     i_rs,
	input  mips_ex_pkg::word_t     i_rt,
	input  mips_ex_pkg::word_t     i_imm,
	input  mips_ex_pkg::reg_addr_t i_rt_addr,
	input  mips_ex_pkg::reg_addr_t i_rd_addr,
	// DUT outputs
	input  logic                   i_o_branch,
	input  logic                   i_o_memread,
	input  logic                   i_o_memwrite,
	input  logic                   i_o_memtoreg,
	input  logic                   i_o_regwrite,
	input  logic                   i_o_zero,
	input  mips_ex_pkg::word_t     i_o_branch_target,
	input  mips_ex_pkg::word_t     i_o_alu_result,
	input  mips_ex_pkg::word_t     i_o_rt,
	input  mips_ex_pkg::reg_addr_t i_o_dest_addr,
	// result counts
	output int                     o_errors,
	output int                     o_checks
);

	int                     err_count = 0;
	int                     check_count = 0;
	// set once the register has seen its first edge
	logic                   primed = 1'b0;
	// expected state of the EX/MEM register
	logic                   exp_reset = 1'b1;
	logic [4:0]             exp_ctrl = '0;
	logic                   exp_zero = 1'b0;
	mips_ex_pkg::reg_addr_t exp_dest = '0;
	mips_ex_pkg::word_t     exp_target = '0;
	mips_ex_pkg::word_t     exp_result = '0;
	mips_ex_pkg::word_t     exp_rt = '0;
	string                  res_name = "alu";

	assign o_errors = err_count;
	assign o_checks = check_count;

	// ==================================================
	// reference model
	// ==================================================
	function automatic mips_ex_pkg::word_t shift_right_arith(input mips_ex_pkg::word_t b,
		input logic [4:0] sh);
		mips_ex_pkg::word_t fill;
		fill = b[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
		return (b >> sh) | fill;
	endfunction

	function automatic mips_ex_pkg::word_t expect_result(input logic [1:0] aluop,
		input logic [3:0] other, input mips_ex_pkg::word_t a, input mips_ex_pkg::word_t b,
		input mips_ex_pkg::word_t imm);
		logic [5:0]         funct;
		logic [4:0]         sh;
		mips_ex_pkg::word_t res;
		funct = imm[5:0];
		sh    = imm[10:6];
		res   = a + b;
		if (aluop == 2'd1)
			res = a - b;
		else if (aluop == 2'd2)
		begin
			case (funct)
				mips_ex_pkg::FUNCT_SUB, mips_ex_pkg::FUNCT_SUBU: res = a - b;
				mips_ex_pkg::FUNCT_AND:  res = a & b;
				mips_ex_pkg::FUNCT_OR:   res = a | b;
				mips_ex_pkg::FUNCT_XOR:  res = a ^ b;
				mips_ex_pkg::FUNCT_NOR:  res = ~(a | b);
				mips_ex_pkg::FUNCT_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_ex_pkg::FUNCT_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				mips_ex_pkg::FUNCT_SLL:  res = b << sh;
				mips_ex_pkg::FUNCT_SRL:  res = b >> sh;
				mips_ex_pkg::FUNCT_SRA:  res = shift_right_arith(b, sh);
				mips_ex_pkg::FUNCT_SLLV: res = b << a[4:0];
				mips_ex_pkg::FUNCT_SRLV: res = b >> a[4:0];
				mips_ex_pkg::FUNCT_SRAV: res = shift_right_arith(b, a[4:0]);
				default:                 res = a + b;
			endcase
		end
		else if (aluop == 2'd3)
		begin
			case (other)
				4'd1:    res = a & b;
				4'd2:    res = a | b;
				4'd3:    res = a ^ b;
				4'd4:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				4'd5:    res = (a < b) ? 32'd1 : 32'd0;
				4'd6:    res = b << 16;
				default: res = a + b;
			endcase
		end
		return res;
	endfunction

	function automatic string check_name(input string base);
		return exp_reset ? {"reset_", base} : base;
	endfunction

	task automatic compare_value(input string name, input mips_ex_pkg::word_t exp,
		input mips_ex_pkg::word_t act);
		check_count++;
		if (exp !== act)
		begin
			err_count++;
			$display("FAIL %s: expected %h, actual %h (time %0t)", name, exp, act, $time);
		end
	endtask

	// ==================================================
	// compare then capture
	// ==================================================
	always @(posedge i_clk)
	begin
		// outputs still hold what the previous edge registered
		if (primed)
		begin
			compare_value(check_name("control"), 32'(exp_ctrl),
				32'({i_o_branch, i_o_memread, i_o_memwrite, i_o_memtoreg, i_o_regwrite}));
			compare_value(check_name("dest"), 32'(exp_dest), 32'(i_o_dest_addr));
			compare_value(check_name("rt"), exp_rt, i_o_rt);
			compare_value(check_name("target"), exp_target, i_o_branch_target);
			compare_value(check_name(res_name), exp_result, i_o_alu_result);
			compare_value(check_name("zero"), 32'(exp_zero), 32'(i_o_zero));
		end
		primed = 1'b1;

		if (!i_rst_n)
		begin
			exp_reset  = 1'b1;
			exp_ctrl   = '0;
			exp_dest   = '0;
			exp_rt     = '0;
			exp_target = '0;
			exp_result = '0;
			exp_zero   = 1'b0;
			res_name   = "alu";
		end
		else
		begin
			exp_reset  = 1'b0;
			exp_ctrl   = {i_branch, i_memread, i_memwrite, i_memtoreg, i_regwrite};
			exp_dest   = i_regdst ? i_rd_addr : i_rt_addr;
			exp_rt     = i_rt;
			exp_target = i_next_pc + i_imm * 32'd4;
			exp_result = expect_result(i_aluop, i_other, i_rs, i_alusrc ? i_imm : i_rt, i_imm);
			exp_zero   = (exp_result == 32'd0);
			case (i_aluop)
				2'd0:    res_name = "alu_loadstore";
				2'd1:    res_name = "alu_branch";
				2'd2:    res_name = "alu_rtype";
				default: res_name = "alu_immediate";
			endcase
		end
	end

endmodule

/* verif/tb_top.sv */
// ==================================================
// Execute stage testbench
// ==================================================

module tb_top;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 16;
	localparam int TEST_CYCLES   = 3000;
	localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

	logic                   i_clk;
	logic                   i_rst_n;
	logic                   i_regdst;
	logic                   i_alusrc;
	mips_ex_pkg::alu_op_t   i_aluop;
	mips_ex_pkg::imm_op_t   i_other;
	logic                   i_branch;
	logic                   i_memread;
	logic                   i_memwrite;
	logic                   i_memtoreg;
	logic                   i_regwrite;
	mips_ex_pkg::word_t     i_next_pc;
	mips_ex_pkg::word_t     i_rs;
	mips_ex_pkg::word_t     i_rt;
	mips_ex_pkg::word_t     i_imm;
	mips_ex_pkg::reg_addr_t i_rt_addr;
	mips_ex_pkg::reg_addr_t i_rd_addr;
	logic                   o_branch;
	logic                   o_memread;
	logic                   o_memwrite;
	logic                   o_memtoreg;
	logic                   o_regwrite;
	logic                   o_zero;
	mips_ex_pkg::word_t     o_branch_target;
	mips_ex_pkg::word_t     o_alu_result;
	mips_ex_pkg::word_t     o_rt;
	mips_ex_pkg::reg_addr_t o_dest_addr;
	int                     chk_errors;
	int                     chk_count;

	mips_ex_pkg::funct_t valid_funct [16] = '{
		mips_ex_pkg::FUNCT_SLL,  mips_ex_pkg::FUNCT_SRL,  mips_ex_pkg::FUNCT_SRA,
		mips_ex_pkg::FUNCT_SLLV, mips_ex_pkg::FUNCT_SRLV, mips_ex_pkg::FUNCT_SRAV,
		mips_ex_pkg::FUNCT_ADD,  mips_ex_pkg::FUNCT_ADDU, mips_ex_pkg::FUNCT_SUB,
		mips_ex_pkg::FUNCT_SUBU, mips_ex_pkg::FUNCT_AND,  mips_ex_pkg::FUNCT_OR,
		mips_ex_pkg::FUNCT_XOR,  mips_ex_pkg::FUNCT_NOR,  mips_ex_pkg::FUNCT_SLT,
		mips_ex_pkg::FUNCT_SLTU};

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	exec_top i_exec_top (.*);

	ex_checker u_ex_checker
	(
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_regdst (i_regdst), .i_alusrc (i_alusrc),
		.i_aluop (i_aluop), .i_other (i_other), .i_branch (i_branch),
		.i_memread (i_memread), .i_memwrite (i_memwrite), .i_memtoreg (i_memtoreg),
		.i_regwrite (i_regwrite), .i_next_pc (i_next_pc), .i_rs (i_rs), .i_rt (i_rt),
		.i_imm (i_imm), .i_rt_addr (i_rt_addr), .i_rd_addr (i_rd_addr),
		.i_o_branch (o_branch), .i_o_memread (o_memread), .i_o_memwrite (o_memwrite),
		.i_o_memtoreg (o_memtoreg), .i_o_regwrite (o_regwrite), .i_o_zero (o_zero),
		.i_o_branch_target (o_branch_target), .i_o_alu_result (o_alu_result),
		.i_o_rt (o_rt), .i_o_dest_addr (o_dest_addr),
		.o_errors (chk_errors), .o_checks (chk_count)
	);

	// one random instruction worth of decode outputs
	task automatic drive_random();
		mips_ex_pkg::word_t  imm_raw;
		mips_ex_pkg::word_t  rs_val;
		mips_ex_pkg::funct_t funct;
		int                  mem_sel;
		imm_raw = $urandom();
		rs_val  = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 40) : $urandom();
		if ($urandom_range(0, 7) != 0)
			funct = valid_funct[$urandom_range(0, 15)];
		else
			funct = 6'($urandom_range(0, 63));
		mem_sel = $urandom_range(0, 2);
		i_regdst   <= 1'($urandom_range(0, 1));
		i_alusrc   <= 1'($urandom_range(0, 1));
		i_aluop    <= mips_ex_pkg::alu_op_t'($urandom_range(0, 3));
		i_other    <= mips_ex_pkg::imm_op_t'($urandom_range(0, 6));
		i_branch   <= 1'($urandom_range(0, 1));
		i_memread  <= (mem_sel == 1);
		i_memwrite <= (mem_sel == 2);
		i_memtoreg <= 1'($urandom_range(0, 1));
		i_regwrite <= 1'($urandom_range(0, 1));
		i_next_pc  <= $urandom();
		i_rs       <= rs_val;
		// equal operands now and then for the zero flag
		i_rt       <= ($urandom_range(0, 3) == 0) ? rs_val : $urandom();
		i_imm      <= {{16{imm_raw[15]}}, imm_raw[15:6], funct};
		i_rt_addr  <= 5'($urandom_range(0, 31));
		i_rd_addr  <= 5'($urandom_range(0, 31));
	endtask

	initial
	begin
		void'($urandom(70501));
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_regdst   = 1'b0;
		i_alusrc   = 1'b0;
		i_aluop    = mips_ex_pkg::ALUOP_ADD;
		i_other    = mips_ex_pkg::IMM_ADDI;
		i_branch   = 1'b0;
		i_memread  = 1'b0;
		i_memwrite = 1'b0;
		i_memtoreg = 1'b0;
		i_regwrite = 1'b0;
		i_next_pc  = '0;
		i_rs       = '0;
		i_rt       = '0;
		i_imm      = '0;
		i_rt_addr  = '0;
		i_rd_addr  = '0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_rst_n <= 1'b1;
		repeat (TEST_CYCLES)
		begin
			@(posedge i_clk);
			drive_random();
		end
		// last item still has to reach the checker
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		$display("checker: %0d errors in %0d checks", chk_errors, chk_count);
		if (chk_errors == 0 && chk_count > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// ==================================================
	// watchdog
	// ==================================================
	initial
	begin
		#(WATCHDOG_TIME);
		$display("watchdog: stimulus did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

endmodule

/* tb.f */
source/mips_ex_pkg.sv
source/alu_if.sv
source/alu_decode.sv
source/alu.sv
source/execute.sv
source/exec_top.sv
verif/ex_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
	-Mdir obj_dir -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
